// File: decode_defines.svh
// ####################
// sizing macros for the dual-issue decode stage
// include wherever a width or depth is needed
// ####################
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// queue entries, also the initial fetch credits
`define DEC_QUEUE_DEPTH 8

// queue pointer width, wraps at the depth
`define DEC_PTR_W 3

// architectural registers
`define DEC_REG_W 5
`define DEC_NUM_REGS 32

// perf counter width
`define DEC_CNT_W 64

// writeback ports into the scoreboard
`define DEC_WB_PORTS 2

`endif

// File: decode_pkg.sv
// ####################
// shared micro-op and bus types of the decode stage
// ####################
`include "decode_defines.svh"

package decode_pkg;

  // execution class of a micro-op
  typedef enum logic [2:0] {
    UNIT_ALU    = 3'd0,
    UNIT_BRANCH = 3'd1,
    UNIT_LOAD   = 3'd2,
    UNIT_STORE  = 3'd3,
    UNIT_MUL    = 3'd4,
    UNIT_DIV    = 3'd5
  } unit_e;

  // pre-decoded micro-op as delivered by fetch
  typedef struct packed {
    logic [7:0]            tag;
    unit_e                 unit;
    logic [`DEC_REG_W-1:0] rd;
    logic [`DEC_REG_W-1:0] rs1;
    logic [`DEC_REG_W-1:0] rs2;
  } uop_t;

  // fetch push, slot 0 older
  typedef struct packed {
    logic [1:0]     valid;
    uop_t [1:0]     uop;
  } fetch_pair_t;

  // micro-ops leaving the stage
  typedef struct packed {
    logic [1:0]     valid;
    uop_t [1:0]     uop;
  } issue_pair_t;

  // register write-back
  typedef struct packed {
    logic                  valid;
    logic [`DEC_REG_W-1:0] rd;
  } wb_t;

endpackage

// File: uop_queue.sv
// ####################
// micro-op queue, two pushes and up to two pops per cycle
// popped entries go back to fetch as credits
// ####################
`timescale 1ns/1ps
`include "decode_defines.svh"

module uop_queue (
  input  logic                    clk,
  input  logic                    resetn,
  input  decode_pkg::fetch_pair_t push_i,
  input  logic [1:0]              pop_i,
  output decode_pkg::fetch_pair_t head_o,
  output logic [1:0]              credit_o
);

  localparam int CNT_W = `DEC_PTR_W + 1;

  typedef logic [`DEC_PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0]      cnt_t;

  decode_pkg::uop_t mem [`DEC_QUEUE_DEPTH];

  ptr_t       wr_ptr_q;
  ptr_t       rd_ptr_q;
  cnt_t       cnt_q;
  logic [1:0] num_push;
  ptr_t       wr_ptr_nxt;
  ptr_t       rd_ptr_nxt;

  // fetch keeps slot 1 valid only with slot 0
  assign num_push   = {1'b0, push_i.valid[0]} + {1'b0, push_i.valid[1]};
  assign wr_ptr_nxt = wr_ptr_q + ptr_t'(1);
  assign rd_ptr_nxt = rd_ptr_q + ptr_t'(1);

  always_ff @(posedge clk) begin
    if (push_i.valid[0]) begin
      mem[wr_ptr_q] <= push_i.uop[0];
    end
    if (push_i.valid[1]) begin
      mem[wr_ptr_nxt] <= push_i.uop[1];
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + ptr_t'(num_push);
      rd_ptr_q <= rd_ptr_q + ptr_t'(pop_i);
      cnt_q    <= cnt_q + cnt_t'(num_push) - cnt_t'(pop_i);
    end
  end

  // oldest two entries, presence from occupancy
  assign head_o.valid[0] = (cnt_q != '0);
  assign head_o.valid[1] = (cnt_q > cnt_t'(1));
  assign head_o.uop[0]   = mem[rd_ptr_q];
  assign head_o.uop[1]   = mem[rd_ptr_nxt];

  // one credit per popped entry, same cycle
  assign credit_o = pop_i;

endmodule

// File: reg_scoreboard.sv
// ####################
// register scoreboard with pending bits per register
// issue marks rd pending, writeback releases it
// ####################
`timescale 1ns/1ps
`include "decode_defines.svh"

module reg_scoreboard (
  input  logic                                      clk,
  input  logic                                      resetn,
  input  decode_pkg::fetch_pair_t                   cand_i,
  input  decode_pkg::issue_pair_t                   claim_i,
  input  decode_pkg::wb_t [`DEC_WB_PORTS-1:0]       wb_i,
  output logic [1:0]                                hazard_o
);

  logic [`DEC_NUM_REGS-1:0] pend_q;
  logic [`DEC_NUM_REGS-1:0] pend_nxt;

  // branches and stores leave no result behind
  function automatic logic writes_rd(input decode_pkg::unit_e unit);
    return (unit != decode_pkg::UNIT_BRANCH) && (unit != decode_pkg::UNIT_STORE);
  endfunction

  function automatic logic slot_hazard(input decode_pkg::uop_t u,
                                       input logic [`DEC_NUM_REGS-1:0] pend);
    return pend[u.rs1] | pend[u.rs2] | pend[u.rd];
  endfunction

  always_comb begin
    pend_nxt = pend_q;
    for (int s = 0; s < 2; s++) begin
      if (claim_i.valid[s] && writes_rd(claim_i.uop[s].unit)) begin
        pend_nxt[claim_i.uop[s].rd] = 1'b1;
      end
    end
    // writeback after claims so a release wins
    for (int p = 0; p < `DEC_WB_PORTS; p++) begin
      if (wb_i[p].valid) begin
        pend_nxt[wb_i[p].rd] = 1'b0;
      end
    end
    // x0 is hardwired
    pend_nxt[0] = 1'b0;
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      pend_q <= '0;
    end else begin
      pend_q <= pend_nxt;
    end
  end

  // lookup against the registered state only
  assign hazard_o[0] = cand_i.valid[0] & slot_hazard(cand_i.uop[0], pend_q);
  assign hazard_o[1] = cand_i.valid[1] & slot_hazard(cand_i.uop[1], pend_q);

endmodule

// File: issue_ctrl.sv
// ####################
// issue decision for the two oldest micro-ops
// tracks an in-flight divide and registers the issued pair
// ####################
`timescale 1ns/1ps

module issue_ctrl (
  input  logic                    clk,
  input  logic                    resetn,
  input  decode_pkg::fetch_pair_t head_i,
  input  logic [1:0]              hazard_i,
  input  logic                    stall_i,
  input  logic                    div_done_i,
  output logic [1:0]              pop_o,
  output decode_pkg::issue_pair_t claim_o,
  output decode_pkg::issue_pair_t issue_o
);

  typedef enum logic {
    RUN      = 1'b0,
    DIV_BUSY = 1'b1
  } state_e;

  state_e           state_q;
  state_e           state_nxt;
  decode_pkg::uop_t u0;
  decode_pkg::uop_t u1;
  logic             is_div0;
  logic             is_div1;
  logic             go0;
  logic             go1;
  logic             no_reg_conflict;
  logic             no_unit_conflict;
  logic             div_issue;
  logic [1:0]       issue_vld_q;
  decode_pkg::uop_t [1:0] issue_uop_q;

  assign u0      = head_i.uop[0];
  assign u1      = head_i.uop[1];
  assign is_div0 = (u0.unit == decode_pkg::UNIT_DIV);
  assign is_div1 = (u1.unit == decode_pkg::UNIT_DIV);

  // slot 1 must not read or overwrite slot 0's result
  assign no_reg_conflict = ((u1.rs1 != u0.rd) && (u1.rs2 != u0.rd) && (u1.rd != u0.rd)) ||
                           (u0.rd == '0);

  // only ALUs are duplicated
  assign no_unit_conflict = (u0.unit != u1.unit) || (u0.unit == decode_pkg::UNIT_ALU);

  assign go0 = head_i.valid[0] & ~hazard_i[0] & ~stall_i &
               ~(is_div0 & (state_q == DIV_BUSY));

  assign go1 = go0 & head_i.valid[1] & ~hazard_i[1] & no_reg_conflict & no_unit_conflict &
               (u0.unit != decode_pkg::UNIT_BRANCH) &
               ~(is_div1 & ((state_q == DIV_BUSY) | is_div0));

  assign pop_o         = {1'b0, go0} + {1'b0, go1};
  assign claim_o.valid = {go1, go0};
  assign claim_o.uop   = head_i.uop;

  assign div_issue = (go0 & is_div0) | (go1 & is_div1);

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      RUN:      if (div_issue) state_nxt = DIV_BUSY;
      DIV_BUSY: if (div_done_i) state_nxt = RUN;
      default:  state_nxt = RUN;
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state_q     <= RUN;
      issue_vld_q <= '0;
    end else begin
      state_q     <= state_nxt;
      issue_vld_q <= claim_o.valid;
    end
  end

  // payload follows the valids
  always_ff @(posedge clk) begin
    issue_uop_q <= head_i.uop;
  end

  assign issue_o = '{valid: issue_vld_q, uop: issue_uop_q};

endmodule

// File: perf_counters.sv
// ####################
// cycle and retired-instruction counters
// ####################
`timescale 1ns/1ps
`include "decode_defines.svh"

module perf_counters (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic [1:0]            retire_i,
  output logic [`DEC_CNT_W-1:0] cycle_cnt_o,
  output logic [`DEC_CNT_W-1:0] instr_cnt_o
);

  typedef logic [`DEC_CNT_W-1:0] cnt_t;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      cycle_cnt_o <= '0;
      instr_cnt_o <= '0;
    end else begin
      cycle_cnt_o <= cycle_cnt_o + cnt_t'(1);
      // 0, 1 or 2 retired per cycle
      instr_cnt_o <= instr_cnt_o + cnt_t'(retire_i);
    end
  end

endmodule

// File: dual_decode.sv
// ####################
// dual-issue decode stage top
// fetch pushes against credits, issue_o feeds execute
// ####################
`timescale 1ns/1ps
`include "decode_defines.svh"

module dual_decode (
  input  logic                                clk,
  input  logic                                resetn,
  input  decode_pkg::fetch_pair_t             fetch_i,
  input  decode_pkg::wb_t [`DEC_WB_PORTS-1:0] wb_i,
  input  logic                                div_done_i,
  input  logic                                stall_i,
  output decode_pkg::issue_pair_t             issue_o,
  output logic [1:0]                          credit_o,
  output logic [`DEC_CNT_W-1:0]               cycle_cnt_o,
  output logic [`DEC_CNT_W-1:0]               instr_cnt_o
);

  decode_pkg::fetch_pair_t head;
  decode_pkg::issue_pair_t claim;
  logic [1:0]              hazard;
  logic [1:0]              pop;

  uop_queue u_queue (
    .clk      (clk),
    .resetn   (resetn),
    .push_i   (fetch_i),
    .pop_i    (pop),
    .head_o   (head),
    .credit_o (credit_o)
  );

  // same candidates seen by issue and scoreboard
  reg_scoreboard u_scoreboard (
    .clk      (clk),
    .resetn   (resetn),
    .cand_i   (head),
    .claim_i  (claim),
    .wb_i     (wb_i),
    .hazard_o (hazard)
  );

  issue_ctrl u_issue (
    .clk        (clk),
    .resetn     (resetn),
    .head_i     (head),
    .hazard_i   (hazard),
    .stall_i    (stall_i),
    .div_done_i (div_done_i),
    .pop_o      (pop),
    .claim_o    (claim),
    .issue_o    (issue_o)
  );

  perf_counters u_perf (
    .clk         (clk),
    .resetn      (resetn),
    .retire_i    (pop),
    .cycle_cnt_o (cycle_cnt_o),
    .instr_cnt_o (instr_cnt_o)
  );

endmodule

// File: tb_dual_decode.sv
// ####################
// testbench for the dual-issue decode stage
// replays the input program and checks the DUT cycle by cycle
// ####################
`timescale 1ns/1ps
`include "decode_defines.svh"

module tb_dual_decode;

  typedef logic [`DEC_REG_W-1:0] reg_t;

  logic                                clk;
  logic                                resetn;
  decode_pkg::fetch_pair_t             fetch_i;
  decode_pkg::wb_t [`DEC_WB_PORTS-1:0] wb_i;
  logic                                div_done_i;
  logic                                stall_i;
  decode_pkg::issue_pair_t             issue_o;
  logic [1:0]                          credit_o;
  logic [`DEC_CNT_W-1:0]               cycle_cnt_o;
  logic [`DEC_CNT_W-1:0]               instr_cnt_o;

  // six hex words per micro-op
  logic [15:0]              prog [0:511];
  logic                     loaded;
  int                       n_prog;
  int                       exp_total;
  int                       stall_start;
  int                       stall_len;
  // reference model state
  logic [`DEC_NUM_REGS-1:0] pend;
  logic                     div_busy;
  int                       div_due;
  int                       credits;
  int                       returned;
  int                       push_idx;
  int                       queued;
  int                       pop_idx;
  int                       seen;
  int                       cyc;
  int                       wb_reg_q [$];
  int                       wb_due_q [$];
  decode_pkg::issue_pair_t  exp_issue;
  int                       checks;
  int                       errors;
  int                       err_mark;

  dual_decode uut (
    .clk         (clk),
    .resetn      (resetn),
    .fetch_i     (fetch_i),
    .wb_i        (wb_i),
    .div_done_i  (div_done_i),
    .stall_i     (stall_i),
    .issue_o     (issue_o),
    .credit_o    (credit_o),
    .cycle_cnt_o (cycle_cnt_o),
    .instr_cnt_o (instr_cnt_o)
  );

  always #20 clk = ~clk;

  function automatic decode_pkg::uop_t uop_at(input int idx);
    decode_pkg::uop_t u;
    u.tag  = prog[idx*6][7:0];
    u.unit = decode_pkg::unit_e'(prog[idx*6+1][2:0]);
    u.rd   = prog[idx*6+2][`DEC_REG_W-1:0];
    u.rs1  = prog[idx*6+3][`DEC_REG_W-1:0];
    u.rs2  = prog[idx*6+4][`DEC_REG_W-1:0];
    return u;
  endfunction

  function automatic int latency_at(input int idx);
    return int'(prog[idx*6+5]);
  endfunction

  function automatic logic is_div(input decode_pkg::uop_t u);
    return u.unit == decode_pkg::UNIT_DIV;
  endfunction

  // branches, stores and x0 leave nothing to write back
  function automatic logic has_result(input decode_pkg::uop_t u);
    return (u.unit != decode_pkg::UNIT_BRANCH) && (u.unit != decode_pkg::UNIT_STORE) &&
           (u.rd != '0);
  endfunction

  function automatic logic reg_waiting(input decode_pkg::uop_t u);
    return pend[u.rs1] || pend[u.rs2] || pend[u.rd];
  endfunction

  function automatic logic may_pair(input decode_pkg::uop_t u0, input decode_pkg::uop_t u1);
    logic reg_ok;
    logic unit_ok;
    reg_ok  = (u0.rd == '0) || ((u1.rs1 != u0.rd) && (u1.rs2 != u0.rd) && (u1.rd != u0.rd));
    unit_ok = (u0.unit != u1.unit) || (u0.unit == decode_pkg::UNIT_ALU);
    return reg_ok && unit_ok && (u0.unit != decode_pkg::UNIT_BRANCH) &&
           !(is_div(u0) && is_div(u1));
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s finished with %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  // fetch pushes, writebacks that fall due, div_done and the stall window
  task automatic drive_inputs();
    int n;
    int i;
    int p;
    stall_i = (cyc >= stall_start) && (cyc < stall_start + stall_len);
    n = int'($urandom % 2) + 1;
    if (n > credits) n = credits;
    if (n > n_prog - push_idx) n = n_prog - push_idx;
    fetch_i = '0;
    for (i = 0; i < n; i++) begin
      fetch_i.valid[i] = 1'b1;
      fetch_i.uop[i]   = uop_at(push_idx + i);
    end
    credits  -= n;
    push_idx += n;
    wb_i = '0;
    i = 0;
    p = 0;
    while ((i < wb_reg_q.size()) && (p < `DEC_WB_PORTS)) begin
      if (wb_due_q[i] <= cyc) begin
        wb_i[p].valid = 1'b1;
        wb_i[p].rd    = reg_t'(wb_reg_q[i]);
        p++;
        wb_reg_q.delete(i);
        wb_due_q.delete(i);
      end else begin
        i++;
      end
    end
    div_done_i = (div_due == cyc);
  endtask

  task automatic check_cycle();
    int               s;
    int               avail;
    logic             go0;
    logic             go1;
    decode_pkg::uop_t u0;
    decode_pkg::uop_t u1;
    decode_pkg::uop_t u;
    // issue_o carries last cycle's decision
    check_value("issue_o.valid", 64'(issue_o.valid), 64'(exp_issue.valid));
    for (s = 0; s < 2; s++) begin
      if (exp_issue.valid[s]) begin
        check_value("issue_o.uop", 64'(issue_o.uop[s]), 64'(exp_issue.uop[s]));
      end
    end
    seen += int'(issue_o.valid[0]) + int'(issue_o.valid[1]);
    check_value("instr_cnt_o", instr_cnt_o, 64'(seen));
    // one edge after reset release the count is 1
    check_value("cycle_cnt_o", cycle_cnt_o, 64'(cyc + 1));
    // this cycle's decision from the model
    avail = queued - pop_idx;
    u0    = uop_at(pop_idx);
    u1    = uop_at(pop_idx + 1);
    go0   = !stall_i && (avail >= 1) && !reg_waiting(u0) && !(is_div(u0) && div_busy);
    go1   = go0 && (avail >= 2) && !reg_waiting(u1) && may_pair(u0, u1) &&
            !(is_div(u1) && div_busy);
    if (stall_i) begin
      check_value("credit_o under stall", 64'(credit_o), 64'd0);
    end
    check_value("credit_o", 64'(credit_o), 64'(go0) + 64'(go1));
    credits  += int'(credit_o);
    returned += int'(credit_o);
    check_value("credits_in_range", 64'(credits <= `DEC_QUEUE_DEPTH), 64'd1);
    // state seen by the DUT next cycle
    if (div_done_i) div_busy = 1'b0;
    exp_issue.valid  = {go1, go0};
    exp_issue.uop[0] = u0;
    exp_issue.uop[1] = u1;
    for (s = 0; s < 2; s++) begin
      u = exp_issue.uop[s];
      if (exp_issue.valid[s] && has_result(u)) begin
        pend[u.rd] = 1'b1;
        wb_reg_q.push_back(int'(u.rd));
        wb_due_q.push_back(cyc + latency_at(pop_idx + s));
      end
      if (exp_issue.valid[s] && is_div(u)) begin
        div_busy = 1'b1;
        div_due  = cyc + latency_at(pop_idx + s);
      end
    end
    for (s = 0; s < `DEC_WB_PORTS; s++) begin
      if (wb_i[s].valid) pend[wb_i[s].rd] = 1'b0;
    end
    pop_idx += int'(go0) + int'(go1);
    queued   = push_idx;
  endtask

  initial begin
    clk        = 1'b0;
    resetn     = 1'b0;
    fetch_i    = '0;
    wb_i       = '0;
    div_done_i = 1'b0;
    stall_i    = 1'b0;
    loaded     = 1'b0;
    pend       = '0;
    div_busy   = 1'b0;
    div_due    = -1;
    credits    = `DEC_QUEUE_DEPTH;
    returned   = 0;
    push_idx   = 0;
    queued     = 0;
    pop_idx    = 0;
    seen       = 0;
    cyc        = 0;
    exp_issue  = '0;
    checks     = 0;
    errors     = 0;
    err_mark   = 0;
    void'($urandom(32'hed49));
    $readmemh("tb_dual_decode_input.txt", prog);
    n_prog = 0;
    while ((n_prog < 80) && (prog[n_prog*6] !== 16'hffff)) n_prog++;
    if (prog[n_prog*6] !== 16'hffff) begin
      errors++;
      $display("program file has no closing line, nothing was run");
      n_prog = 0;
    end
    exp_total   = int'(prog[n_prog*6+1]);
    stall_start = int'(prog[n_prog*6+2]);
    stall_len   = int'(prog[n_prog*6+3]);
    loaded      = 1'b1;
    repeat (16) @(posedge clk);
    #1 resetn = 1'b1;
    while ((pop_idx < n_prog) || (exp_issue.valid != '0)) begin
      @(posedge clk);
      #1;
      drive_inputs();
      @(negedge clk);
      check_cycle();
      cyc++;
    end
    report_test("issue_stream");
    check_value("credits after drain", 64'(credits), 64'(`DEC_QUEUE_DEPTH));
    check_value("credits returned", 64'(returned), 64'(push_idx));
    check_value("entries pushed", 64'(push_idx), 64'(n_prog));
    report_test("credit_return");
    check_value("instr_cnt_o total", instr_cnt_o, 64'(exp_total));
    check_value("issued total", 64'(seen), 64'(exp_total));
    report_test("counters");
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // program length times 20 cycles plus reset
  initial begin
    wait (loaded);
    repeat (16 + 20 * n_prog + 20) @(posedge clk);
    $display("timeout, the program did not drain within %0d cycles", 20 * n_prog);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: tb_dual_decode_input.txt
// columns: tag unit rd rs1 rs2 wb_latency, all hex; unit 0 alu 1 branch 2 load 3 store 4 mul 5 div
// closing line: ffff expected_total stall_start_cycle stall_cycles 0 0
00 0 01 00 00 1
01 0 02 00 00 1
02 0 03 01 02 2
03 0 04 01 02 1
04 2 05 03 00 4
05 0 06 05 04 1
06 4 07 06 03 3
07 4 08 04 04 3
08 5 09 07 08 6
09 5 0a 01 02 5
0a 0 0b 09 00 1
0b 1 00 0b 0a 1
0c 0 0c 01 01 1
0d 3 00 0c 02 1
0e 3 00 0d 03 1
0f 0 0d 00 00 2
10 0 0e 0d 00 1
11 0 00 01 02 1
12 0 0f 00 00 1
13 2 10 0f 00 3
14 4 11 10 10 2
15 0 12 11 00 1
16 0 13 12 12 1
17 5 14 13 00 4
18 0 15 14 00 1
19 0 16 00 00 1
1a 1 00 16 15 1
1b 0 17 00 00 2
1c 0 18 17 00 1
1d 2 19 18 00 2
1e 3 00 19 18 1
1f 0 1a 1a 00 1
ffff 20 0c 06 0 0

// File: dual_decode.f
+incdir+.
decode_pkg.sv
uop_queue.sv
reg_scoreboard.sv
issue_ctrl.sv
perf_counters.sv
dual_decode.sv
tb_dual_decode.sv

// File: Makefile
TOP = tb_dual_decode

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f dual_decode.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

lint:
	verilator --lint-only --timing --top-module dual_decode -f dual_decode.f

clean:
	rm -rf obj_dir
